//--- regblk_pkg.sv
package regblk_pkg;

  localparam int DATA_W       = 32;
  localparam int HOST_ADDR_W  = 16;
  localparam int LOCAL_ADDR_W = 8;
  localparam int EXT_ADDR_W   = 7;
  localparam int STRB_W       = DATA_W / 8;
  localparam int FIELD_W      = 16;
  localparam int NUM_FLAGS    = 2;

  localparam logic [LOCAL_ADDR_W-1:0] REG_CTRL       = 8'h00;
  localparam logic [LOCAL_ADDR_W-1:0] REG_DATA       = 8'h04;
  localparam logic [LOCAL_ADDR_W-1:0] REG_STATUS     = 8'h08;
  localparam logic [LOCAL_ADDR_W-1:0] REG_SAMPLE     = 8'h0C;
  localparam logic [LOCAL_ADDR_W-1:0] REG_INT_STATUS = 8'h24;
  localparam logic [LOCAL_ADDR_W-1:0] REG_EVENT      = 8'h28;
  localparam logic [LOCAL_ADDR_W-1:0] EXT_BASE       = 8'h80; // Window runs to 0xFF

  localparam int FLAG_HI_BIT = 8;
  localparam int FLAG_LO_BIT = 0;

  // High bit doubles as the error flag
  typedef enum logic [1:0] {
    STATUS_OK     = 2'b00,
    STATUS_EXOKAY = 2'b01,
    STATUS_SLVERR = 2'b10
  } status_t;

  typedef struct packed {
    logic [HOST_ADDR_W-1:0] paddr;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [DATA_W-1:0]      pwdata;
    logic [STRB_W-1:0]      pstrb;
  } apb_req_t;

  typedef struct packed {
    logic              pready;
    logic [DATA_W-1:0] prdata;
    logic              pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic                    valid;
    logic                    write;
    logic                    read;
    logic [LOCAL_ADDR_W-1:0] address;
    logic [STRB_W-1:0]       strobe;
    logic [DATA_W-1:0]       write_data;
    logic [DATA_W-1:0]       write_mask;
  } cmd_t;

  typedef struct packed {
    logic              ready;
    logic [DATA_W-1:0] read_data;
    status_t           status;
  } rsp_t;

  typedef struct packed {
    logic                  valid;
    logic                  write;
    logic                  read;
    logic [EXT_ADDR_W-1:0] address;
    logic [STRB_W-1:0]     strobe;
    logic [DATA_W-1:0]     write_data;
  } ext_req_t;

  typedef struct packed {
    logic              ready;
    logic [DATA_W-1:0] read_data;
    status_t           status;
  } ext_rsp_t;

  typedef struct packed {
    logic [FIELD_W-1:0]   ctrl_hi;
    logic [FIELD_W-1:0]   ctrl_lo;
    logic [DATA_W-1:0]    data;
    logic                 irq_enable;
    logic [NUM_FLAGS-1:0] event_flags;
  } ctrl_out_t;

endpackage

//--- regblk_flag_bit.sv
`timescale 1ns/1ps

module regblk_flag_bit #(
  parameter bit SET_MODE    = 1'b0,
  parameter bit CLEAR_VALUE = 1'b1
) (
  input  logic clk,
  input  logic i_arst_n,
  input  logic i_event,
  input  logic i_write_hit,
  input  logic i_write_bit,
  input  logic i_mask_bit,
  output logic o_value
);

  logic sw_hit;
  logic flag;

  // Software acts only on a strobed write of the matching value
  assign sw_hit = i_write_hit && i_mask_bit && (i_write_bit == CLEAR_VALUE);

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      flag <= 1'b0;
    end else if (i_event) begin
      flag <= !SET_MODE; // Hardware has priority
    end else if (sw_hit) begin
      flag <= SET_MODE;
    end
  end

  assign o_value = flag;

endmodule

//--- regblk_apb_host.sv
`timescale 1ns/1ps

module regblk_apb_host
  import regblk_pkg::*;
(
  input  logic     clk,
  input  logic     i_arst_n,
  input  apb_req_t i_apb,
  input  rsp_t     i_rsp,
  output apb_rsp_t o_apb,
  output cmd_t     o_cmd
);

  logic busy;
  logic access;
  logic [DATA_W-1:0] mask;

  assign access = i_apb.psel && i_apb.penable;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      busy <= 1'b0;
    end else if (o_cmd.valid) begin
      busy <= 1'b1;
    end else if (i_rsp.ready) begin
      busy <= 1'b0;
    end
  end

  always_comb begin
    for (int i = 0; i < STRB_W; i++) begin
      mask[8*i+:8] = {8{i_apb.pstrb[i]}}; // Byte lane enable
    end
  end

  assign o_cmd.valid      = access && !busy; // First access cycle only
  assign o_cmd.write      = i_apb.pwrite;
  assign o_cmd.read       = !i_apb.pwrite;
  assign o_cmd.address    = i_apb.paddr[LOCAL_ADDR_W-1:0];
  assign o_cmd.strobe     = i_apb.pstrb;
  assign o_cmd.write_data = i_apb.pwdata;
  assign o_cmd.write_mask = mask;

  assign o_apb.pready  = i_rsp.ready;
  assign o_apb.prdata  = i_rsp.read_data;
  assign o_apb.pslverr = i_rsp.status[1];

  // Every completion must belong to an outstanding command
  a_rsp_only_when_busy: assert property (
    @(posedge clk) disable iff (!i_arst_n)
    i_rsp.ready |-> busy
  );

  // The transfer ends on pready, so the next command needs a fresh access phase
  a_no_cmd_after_done: assert property (
    @(posedge clk) disable iff (!i_arst_n)
    o_apb.pready |=> !o_cmd.valid
  );

endmodule

//--- regblk_register_bank.sv
`timescale 1ns/1ps

module regblk_register_bank
  import regblk_pkg::*;
(
  input  logic                 clk,
  input  logic                 i_arst_n,
  input  cmd_t                 i_cmd,
  input  logic                 i_status_in,
  input  logic [DATA_W-1:0]    i_sample,
  input  logic [NUM_FLAGS-1:0] i_int_set,
  input  logic [NUM_FLAGS-1:0] i_event_clear,
  output rsp_t                 o_rsp,
  output logic                 o_ext_select,
  output ctrl_out_t            o_ctrl,
  output logic                 o_irq
);

  localparam int WORD_W = LOCAL_ADDR_W - 2;

  logic [WORD_W-1:0]    word_addr;
  logic                 ext_hit;
  logic                 wr_en;
  logic                 mapped;
  logic                 sel_ctrl;
  logic                 sel_data;
  logic                 sel_status;
  logic                 sel_int;
  logic                 sel_event;
  logic [DATA_W-1:0]    read_word;
  logic [FIELD_W-1:0]   ctrl_hi;
  logic [FIELD_W-1:0]   ctrl_lo;
  logic [DATA_W-1:0]    data;
  logic                 irq_enable;
  logic [NUM_FLAGS-1:0] int_flags;
  logic [NUM_FLAGS-1:0] event_flags;
  logic                 irq;

  function automatic logic [DATA_W-1:0] merge(input logic [DATA_W-1:0] cur,
                                              input logic [DATA_W-1:0] wdata,
                                              input logic [DATA_W-1:0] wmask);
    return (cur & ~wmask) | (wdata & wmask);
  endfunction

  assign word_addr = i_cmd.address[LOCAL_ADDR_W-1:2];
  assign ext_hit   = i_cmd.address >= EXT_BASE;
  assign wr_en     = i_cmd.valid && i_cmd.write;

  always_comb begin
    sel_ctrl   = 1'b0;
    sel_data   = 1'b0;
    sel_status = 1'b0;
    sel_int    = 1'b0;
    sel_event  = 1'b0;
    mapped     = 1'b1;
    read_word  = '0;
    case (word_addr)
      REG_CTRL[LOCAL_ADDR_W-1:2]: begin
        sel_ctrl  = 1'b1;
        read_word = {ctrl_hi, ctrl_lo};
      end
      REG_DATA[LOCAL_ADDR_W-1:2]: begin
        sel_data  = 1'b1;
        read_word = data;
      end
      REG_STATUS[LOCAL_ADDR_W-1:2]: begin
        sel_status    = 1'b1;
        read_word[16] = i_status_in; // Read-only input
        read_word[0]  = irq_enable;
      end
      REG_SAMPLE[LOCAL_ADDR_W-1:2]: begin
        read_word = i_sample;
      end
      REG_INT_STATUS[LOCAL_ADDR_W-1:2]: begin
        sel_int                = 1'b1;
        read_word[FLAG_LO_BIT] = int_flags[0];
        read_word[FLAG_HI_BIT] = int_flags[1];
      end
      REG_EVENT[LOCAL_ADDR_W-1:2]: begin
        sel_event              = 1'b1;
        read_word[FLAG_LO_BIT] = event_flags[0];
        read_word[FLAG_HI_BIT] = event_flags[1];
      end
      default: mapped = 1'b0; // Unmapped reads as zero
    endcase
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ctrl_hi    <= '0;
      ctrl_lo    <= '0;
      data       <= '0;
      irq_enable <= 1'b0;
    end else if (wr_en) begin
      if (sel_ctrl) begin
        {ctrl_hi, ctrl_lo} <= merge({ctrl_hi, ctrl_lo}, i_cmd.write_data, i_cmd.write_mask);
      end
      if (sel_data) begin
        data <= merge(data, i_cmd.write_data, i_cmd.write_mask);
      end
      if (sel_status && i_cmd.write_mask[0]) begin
        irq_enable <= i_cmd.write_data[0];
      end
    end
  end

  // Index 0 sits at bit 0 and clears or sets on 1, index 1 at bit 8 on 0
  for (genvar i = 0; i < NUM_FLAGS; i++) begin : g_flag
    localparam int POS = (i == 0) ? FLAG_LO_BIT : FLAG_HI_BIT;

    regblk_flag_bit #(
      .SET_MODE    (1'b0),
      .CLEAR_VALUE (i == 0)
    ) u_int_flag (
      .clk         (clk),
      .i_arst_n    (i_arst_n),
      .i_event     (i_int_set[i]),
      .i_write_hit (wr_en && sel_int),
      .i_write_bit (i_cmd.write_data[POS]),
      .i_mask_bit  (i_cmd.write_mask[POS]),
      .o_value     (int_flags[i])
    );

    regblk_flag_bit #(
      .SET_MODE    (1'b1),
      .CLEAR_VALUE (i == 0)
    ) u_event_flag (
      .clk         (clk),
      .i_arst_n    (i_arst_n),
      .i_event     (i_event_clear[i]),
      .i_write_hit (wr_en && sel_event),
      .i_write_bit (i_cmd.write_data[POS]),
      .i_mask_bit  (i_cmd.write_mask[POS]),
      .o_value     (event_flags[i])
    );
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      irq <= 1'b0;
    end else begin
      irq <= irq_enable && |int_flags;
    end
  end

  always_comb begin
    o_rsp.ready     = i_cmd.valid && !ext_hit;
    o_rsp.read_data = read_word;
    if (mapped) begin
      o_rsp.status = STATUS_OK;
    end else begin
      o_rsp.status = STATUS_SLVERR;
    end
  end

  assign o_ext_select = ext_hit;
  assign o_irq        = irq;

  assign o_ctrl.ctrl_hi     = ctrl_hi;
  assign o_ctrl.ctrl_lo     = ctrl_lo;
  assign o_ctrl.data        = data;
  assign o_ctrl.irq_enable  = irq_enable;
  assign o_ctrl.event_flags = event_flags;

endmodule

//--- regblk_bus_exporter.sv
`timescale 1ns/1ps

module regblk_bus_exporter
  import regblk_pkg::*;
(
  input  logic     clk,
  input  logic     i_arst_n,
  input  cmd_t     i_cmd,
  input  logic     i_select,
  input  ext_rsp_t i_ext,
  output ext_req_t o_ext,
  output rsp_t     o_rsp
);

  logic     start;
  ext_req_t req;

  assign start = i_cmd.valid && i_select;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      req <= '0;
    end else if (req.valid) begin
      if (i_ext.ready) begin
        req.valid <= 1'b0;
      end
    end else if (start) begin
      req.valid      <= 1'b1; // Payload is held through back-pressure
      req.write      <= i_cmd.write;
      req.read       <= i_cmd.read;
      req.address    <= EXT_ADDR_W'(i_cmd.address - EXT_BASE); // Window offset
      req.strobe     <= i_cmd.strobe;
      req.write_data <= i_cmd.write_data;
    end
  end

  assign o_ext = req;

  assign o_rsp.ready     = req.valid && i_ext.ready;
  assign o_rsp.read_data = i_ext.read_data;
  assign o_rsp.status    = i_ext.status;

  a_req_stable: assert property (
    @(posedge clk) disable iff (!i_arst_n)
    (o_ext.valid && !i_ext.ready) |=> (o_ext.valid && $stable(o_ext))
  );

endmodule

//--- regblk_response_mux.sv
`timescale 1ns/1ps

module regblk_response_mux
  import regblk_pkg::*;
(
  input  logic clk,
  input  logic i_arst_n,
  input  rsp_t i_bank_rsp,
  input  rsp_t i_ext_rsp,
  output rsp_t o_rsp
);

  logic              ready_q;
  logic [DATA_W-1:0] data_q;
  status_t           status_q;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= i_bank_rsp.ready || i_ext_rsp.ready; // One-cycle pulse
    end
  end

  always_ff @(posedge clk) begin
    if (i_bank_rsp.ready) begin
      data_q   <= i_bank_rsp.read_data;
      status_q <= i_bank_rsp.status;
    end else if (i_ext_rsp.ready) begin
      data_q   <= i_ext_rsp.read_data;
      status_q <= i_ext_rsp.status;
    end
  end

  assign o_rsp.ready     = ready_q;
  assign o_rsp.read_data = data_q;
  assign o_rsp.status    = status_q;

  // Bank and window decode are disjoint, so only one side can answer
  a_one_side_ready: assert property (
    @(posedge clk) disable iff (!i_arst_n)
    !(i_bank_rsp.ready && i_ext_rsp.ready)
  );

endmodule

//--- regblk_top.sv
`timescale 1ns/1ps

module regblk_top
  import regblk_pkg::*;
(
  input  logic                 clk,
  input  logic                 i_arst_n,
  input  apb_req_t             i_apb,
  input  logic                 i_status_in,
  input  logic [DATA_W-1:0]    i_sample,
  input  logic [NUM_FLAGS-1:0] i_int_set,
  input  logic [NUM_FLAGS-1:0] i_event_clear,
  input  ext_rsp_t             i_ext,
  output apb_rsp_t             o_apb,
  output ctrl_out_t            o_ctrl,
  output logic                 o_irq,
  output ext_req_t             o_ext
);

  cmd_t cmd;
  rsp_t bank_rsp;
  rsp_t ext_rsp;
  rsp_t rsp;
  logic ext_select;

  regblk_apb_host u_host (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_apb    (i_apb),
    .i_rsp    (rsp),
    .o_apb    (o_apb),
    .o_cmd    (cmd)
  );

  regblk_register_bank u_bank (
    .clk           (clk),
    .i_arst_n      (i_arst_n),
    .i_cmd         (cmd),
    .i_status_in   (i_status_in),
    .i_sample      (i_sample),
    .i_int_set     (i_int_set),
    .i_event_clear (i_event_clear),
    .o_rsp         (bank_rsp),
    .o_ext_select  (ext_select),
    .o_ctrl        (o_ctrl),
    .o_irq         (o_irq)
  );

  regblk_bus_exporter u_exporter (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_cmd    (cmd),
    .i_select (ext_select),
    .i_ext    (i_ext),
    .o_ext    (o_ext),
    .o_rsp    (ext_rsp)
  );

  regblk_response_mux u_mux (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_bank_rsp (bank_rsp),
    .i_ext_rsp  (ext_rsp),
    .o_rsp      (rsp)
  );

endmodule

//--- tb_regblk.sv
`timescale 1ns/1ps

module tb_regblk
  import regblk_pkg::*;
();

  localparam int NUM_TESTS = 6;
  localparam int SEED      = 67274;
  localparam int EXT_WORDS = 32;
  localparam int UPPER_W   = HOST_ADDR_W - LOCAL_ADDR_W;

  logic                  clk = 1'b0;
  logic                  arst_n;
  apb_req_t              apb_req;
  apb_rsp_t              apb_rsp;
  logic                  status_in;
  logic [DATA_W-1:0]     sample;
  logic [NUM_FLAGS-1:0]  int_set;
  logic [NUM_FLAGS-1:0]  event_clear;
  ext_req_t              ext_req;
  ext_rsp_t              ext_rsp;
  ctrl_out_t             ctrl;
  logic                  irq;

  ctrl_out_t             exp_ctrl;            // Shadow of the read-write fields
  logic [DATA_W-1:0]     ext_mem [EXT_WORDS]; // Storage of the external model
  logic [DATA_W-1:0]     exp_mem [EXT_WORDS];
  logic                  ext_error;           // Model answers with SLVERR
  logic [EXT_ADDR_W-1:0] ext_seen_addr;
  logic                  ext_seen_write;
  logic                  ext_seen_read;
  int                    ext_delay;

  always #5 clk = ~clk;

  regblk_top regblk_top_i (
    .clk           (clk),
    .i_arst_n      (arst_n),
    .i_apb         (apb_req),
    .i_status_in   (status_in),
    .i_sample      (sample),
    .i_int_set     (int_set),
    .i_event_clear (event_clear),
    .i_ext         (ext_rsp),
    .o_apb         (apb_rsp),
    .o_ctrl        (ctrl),
    .o_irq         (irq),
    .o_ext         (ext_req)
  );

  function automatic logic [DATA_W-1:0] apply_strobes(input logic [DATA_W-1:0] old,
                                                      input logic [DATA_W-1:0] wdata,
                                                      input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] res;
    res = old;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        res[8*b+:8] = wdata[8*b+:8];
      end
    end
    return res;
  endfunction

  function automatic logic [DATA_W-1:0] fill_word(input int idx);
    return 32'hC0DE_0000 + DATA_W'(idx * 4); // Byte address of the word
  endfunction

  function automatic logic [DATA_W-1:0] status_word();
    return {15'b0, status_in, 15'b0, exp_ctrl.irq_enable};
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_status(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_ctrl(input ctrl_out_t got, input ctrl_out_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("[FAIL] o_ctrl got 0x%h expected 0x%h", got, exp));
    end
  endtask

  task automatic check_irq(input logic got, input logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("[FAIL] o_irq got 0x%h expected 0x%h", got, exp));
    end
  endtask

  task automatic apb_access(input logic wr, input logic [LOCAL_ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] strb,
                            output logic [DATA_W-1:0] rdata, output logic err);
    int waits;
    waits = 0;
    apb_req.paddr   = {UPPER_W'($urandom()), addr}; // Upper bits are not decoded
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.pwdata  = wdata;
    apb_req.pstrb   = strb;
    @(negedge clk);
    apb_req.penable = 1'b1;
    do begin
      @(negedge clk);
      waits++;
    end while (!apb_rsp.pready);
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(negedge clk); // Transfer completes on the edge before this one
    apb_req = '0;
    if (addr < EXT_BASE) begin
      if (waits != 1) begin
        stop_on_error($sformatf("Internal access at 0x%h did not end in its second cycle", addr));
      end
    end else begin
      check_data("o_ext.address", DATA_W'(ext_seen_addr), DATA_W'(addr - EXT_BASE));
      check_status("o_ext.write", ext_seen_write, wr);
      check_status("o_ext.read", ext_seen_read, !wr);
      if (waits != ext_delay + 2) begin
        stop_on_error($sformatf("pready at 0x%h did not follow the external ready", addr));
      end
    end
  endtask

  task automatic apb_write(input logic [LOCAL_ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                           input logic [STRB_W-1:0] strb, input logic exp_err);
    logic [DATA_W-1:0] rdata;
    logic              err;
    apb_access(1'b1, addr, wdata, strb, rdata, err);
    check_status($sformatf("pslverr write 0x%h", addr), err, exp_err);
  endtask

  task automatic apb_read(input logic [LOCAL_ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp_data,
                          input logic exp_err);
    logic [DATA_W-1:0] rdata;
    logic              err;
    apb_access(1'b0, addr, '0, '0, rdata, err);
    check_status($sformatf("pslverr read 0x%h", addr), err, exp_err);
    check_data($sformatf("prdata 0x%h", addr), rdata, exp_data);
  endtask

  task automatic pulse_flag_inputs(input logic [NUM_FLAGS-1:0] set_v,
                                   input logic [NUM_FLAGS-1:0] clear_v);
    int_set     = set_v;
    event_clear = clear_v;
    @(negedge clk);
    int_set     = '0;
    event_clear = '0;
  endtask

  task automatic test_rw_fields();
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] strb;
    apb_write(REG_CTRL, 32'h1234_5678, 4'hF, 1'b0);
    {exp_ctrl.ctrl_hi, exp_ctrl.ctrl_lo} = 32'h1234_5678;
    apb_write(REG_CTRL, 32'hAABB_CCDD, 4'b0101, 1'b0);
    {exp_ctrl.ctrl_hi, exp_ctrl.ctrl_lo} =
      apply_strobes({exp_ctrl.ctrl_hi, exp_ctrl.ctrl_lo}, 32'hAABB_CCDD, 4'b0101);
    apb_read(REG_CTRL, {exp_ctrl.ctrl_hi, exp_ctrl.ctrl_lo}, 1'b0);
    check_ctrl(ctrl, exp_ctrl);
    for (int n = 0; n < 8; n++) begin
      wdata = $urandom();
      strb  = STRB_W'($urandom_range(15, 1));
      apb_write(REG_DATA, wdata, strb, 1'b0);
      exp_ctrl.data = apply_strobes(exp_ctrl.data, wdata, strb);
      apb_read(REG_DATA, exp_ctrl.data, 1'b0);
      check_ctrl(ctrl, exp_ctrl);
    end
  endtask

  task automatic test_read_only();
    sample    = $urandom();
    status_in = 1'b1;
    apb_read(REG_SAMPLE, sample, 1'b0);
    apb_read(REG_STATUS, status_word(), 1'b0);
    apb_write(REG_SAMPLE, ~sample, 4'hF, 1'b0);
    apb_read(REG_SAMPLE, sample, 1'b0);
    apb_write(REG_STATUS, 32'hFFFE_FFFE, 4'hF, 1'b0); // Tries to clear bit 16
    exp_ctrl.irq_enable = 1'b0;
    apb_read(REG_STATUS, status_word(), 1'b0);
    status_in = 1'b0;
    apb_write(REG_STATUS, 32'h0001_0001, 4'hF, 1'b0);
    exp_ctrl.irq_enable = 1'b1;
    apb_read(REG_STATUS, status_word(), 1'b0);
    check_ctrl(ctrl, exp_ctrl);
  endtask

  task automatic test_int_flags();
    pulse_flag_inputs(2'b11, 2'b00);
    check_irq(irq, 1'b0); // Flags set, irq follows a cycle later
    @(negedge clk);
    check_irq(irq, 1'b1);
    apb_read(REG_INT_STATUS, 32'h0000_0101, 1'b0);
    apb_write(REG_INT_STATUS, 32'h0000_0101, 4'h3, 1'b0); // A one leaves bit 8 set
    apb_read(REG_INT_STATUS, 32'h0000_0100, 1'b0);
    check_irq(irq, 1'b1);
    apb_write(REG_INT_STATUS, 32'h0000_0000, 4'h2, 1'b0);
    apb_read(REG_INT_STATUS, '0, 1'b0);
    check_irq(irq, 1'b0);
    apb_write(REG_STATUS, '0, 4'h1, 1'b0);
    exp_ctrl.irq_enable = 1'b0;
    pulse_flag_inputs(2'b01, 2'b00);
    repeat (2) @(negedge clk);
    check_irq(irq, 1'b0);
    apb_read(REG_INT_STATUS, 32'h0000_0001, 1'b0);
    apb_write(REG_INT_STATUS, 32'h0000_0001, 4'h1, 1'b0);
    apb_read(REG_INT_STATUS, '0, 1'b0);
    check_ctrl(ctrl, exp_ctrl);
  endtask

  task automatic test_event_flags();
    apb_write(REG_EVENT, 32'h0000_0001, 4'h3, 1'b0); // Sets both flags
    exp_ctrl.event_flags = 2'b11;
    check_ctrl(ctrl, exp_ctrl);
    apb_read(REG_EVENT, 32'h0000_0101, 1'b0);
    apb_write(REG_EVENT, 32'h0000_0100, 4'h3, 1'b0); // Opposite values do nothing
    check_ctrl(ctrl, exp_ctrl);
    pulse_flag_inputs(2'b00, 2'b01);
    exp_ctrl.event_flags = 2'b10;
    check_ctrl(ctrl, exp_ctrl);
    pulse_flag_inputs(2'b00, 2'b10);
    exp_ctrl.event_flags = 2'b00;
    check_ctrl(ctrl, exp_ctrl);
    apb_read(REG_EVENT, '0, 1'b0);
  endtask

  task automatic test_ext_window();
    logic [LOCAL_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]       wdata;
    logic [STRB_W-1:0]       strb;
    int                      idx;
    for (int n = 0; n < 12; n++) begin
      idx   = $urandom_range(EXT_WORDS - 1, 0);
      addr  = EXT_BASE + LOCAL_ADDR_W'(idx * 4);
      wdata = $urandom();
      strb  = STRB_W'($urandom_range(15, 1));
      apb_write(addr, wdata, strb, 1'b0);
      exp_mem[idx] = apply_strobes(exp_mem[idx], wdata, strb);
    end
    for (int n = 0; n < 12; n++) begin
      idx  = $urandom_range(EXT_WORDS - 1, 0);
      addr = EXT_BASE + LOCAL_ADDR_W'(idx * 4);
      apb_read(addr, exp_mem[idx], 1'b0);
    end
    ext_error = 1'b1;
    apb_read(8'hFC, '0, 1'b1);
    ext_error = 1'b0;
  endtask

  task automatic test_unmapped();
    apb_read(8'h40, '0, 1'b1);
    apb_write(8'h40, 32'hFFFF_FFFF, 4'hF, 1'b1);
    check_ctrl(ctrl, exp_ctrl);
  endtask

  // External bus target with a random ready delay
  initial begin : ext_model
    int idx;
    ext_rsp        = '0;
    ext_seen_addr  = '0;
    ext_seen_write = 1'b0;
    ext_seen_read  = 1'b0;
    ext_delay      = 0;
    for (int i = 0; i < EXT_WORDS; i++) begin
      ext_mem[i] = fill_word(i);
    end
    forever begin
      @(negedge clk);
      if (ext_req.valid) begin
        ext_delay = $urandom_range(5, 0);
        repeat (ext_delay) @(negedge clk);
        idx            = int'(ext_req.address[EXT_ADDR_W-1:2]);
        ext_seen_addr  = ext_req.address;
        ext_seen_write = ext_req.write;
        ext_seen_read  = ext_req.read;
        ext_rsp.ready  = 1'b1;
        if (ext_error) begin
          ext_rsp.status    = STATUS_SLVERR;
          ext_rsp.read_data = '0;
        end else begin
          ext_rsp.status    = STATUS_OK;
          ext_rsp.read_data = ext_mem[idx];
          if (ext_req.write) begin
            ext_mem[idx] = apply_strobes(ext_mem[idx], ext_req.write_data, ext_req.strobe);
          end
        end
        @(negedge clk); // Handshake taken on the edge before
        ext_rsp = '0;
      end
    end
  end

  initial begin
    repeat (16 + NUM_TESTS * 200) @(posedge clk);
    stop_on_error("Timeout, the tests did not finish in the expected number of cycles");
  end

  initial begin
    void'($urandom(SEED));
    arst_n      = 1'b0;
    apb_req     = '0;
    status_in   = 1'b0;
    sample      = '0;
    int_set     = '0;
    event_clear = '0;
    ext_error   = 1'b0;
    exp_ctrl    = '0;
    for (int i = 0; i < EXT_WORDS; i++) begin
      exp_mem[i] = fill_word(i);
    end
    repeat (16) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    check_status("pready", apb_rsp.pready, 1'b0);
    check_status("o_ext.valid", ext_req.valid, 1'b0);
    check_irq(irq, 1'b0);
    check_ctrl(ctrl, exp_ctrl);
    test_rw_fields();
    test_read_only();
    test_int_flags();
    test_event_flags();
    test_ext_window();
    test_unmapped();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- src.f
regblk_pkg.sv
regblk_flag_bit.sv
regblk_apb_host.sv
regblk_register_bank.sv
regblk_bus_exporter.sv
regblk_response_mux.sv
regblk_top.sv
tb_regblk.sv

//--- Makefile
# Verilator build and run for the APB register block

VERILATOR ?= verilator
TOP       ?= tb_regblk
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_MSG  ?= *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: compile
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
